// ==== flist.f ====
+incdir+src
src/dcache_pkg.sv
src/dcache_ram.sv
src/dcache_lookup.sv
src/dcache_lru.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/dcache_checker.sv
tb/tb_dcache.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_dcache
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/tb_dcache.sv ====
// Testbench top for the data cache, clock, reset, stimulus table and refill responder
`timescale 1ns/10ps
`include "dcache_settings.svh"

module tb_dcache;
   import dcache_pkg::*;

   localparam int                   NUM_TESTS      = 15;
   localparam int                   TIMEOUT_CYCLES = NUM_TESTS * 40;
   // Memory word at A is A xor this key
   localparam logic [`DC_ADR_W-1:0] MEM_KEY        = 32'ha5c3_5a3c;

   typedef enum logic [1:0] {
      OP_RD,
      OP_WR,
      OP_SPR
   } op_t;

   // One table row, name kept beside it in vec_name
   typedef struct packed {
      op_t                   op;
      logic [`DC_ADR_W-1:0]  adr;
      logic [`DC_ADR_W-1:0]  dat;
      logic [3:0]            bsel;
      logic [`DC_ADR_W-1:0]  exp_dat;
      logic                  chk_dat;
      logic                  exp_refill;
   } test_vec_t;

   logic                  clk;
   logic                  rst;
   logic                  cpu_req_valid;
   cpu_req_t              cpu_req;
   logic                  refill_we;
   refill_beat_t          refill_beat;
   logic                  spr_stb;
   logic                  spr_we;
   logic [15:0]           spr_addr;
   logic [`DC_ADR_W-1:0]  spr_dat;
   logic                  cpu_ack;
   logic [`DC_ADR_W-1:0]  cpu_dat;
   logic                  refill_req;
   logic                  spr_ack;

   test_vec_t  vec [NUM_TESTS];
   string      vec_name [NUM_TESTS];
   int         n_vec;
   int         cycle_cnt;
   int         fails;
   integer     seed;

   dcache_top u_dcache_top (
      .clk             (clk),
      .rst             (rst),
      .cpu_req_valid_i (cpu_req_valid),
      .cpu_req_i       (cpu_req),
      .refill_we_i     (refill_we),
      .refill_beat_i   (refill_beat),
      .spr_stb_i       (spr_stb),
      .spr_we_i        (spr_we),
      .spr_addr_i      (spr_addr),
      .spr_dat_i       (spr_dat),
      .cpu_ack_o       (cpu_ack),
      .cpu_dat_o       (cpu_dat),
      .refill_req_o    (refill_req),
      .spr_ack_o       (spr_ack)
   );

   dcache_checker u_checker (
      .clk          (clk),
      .cpu_ack_i    (cpu_ack),
      .cpu_dat_i    (cpu_dat),
      .refill_req_i (refill_req),
      .spr_ack_i    (spr_ack)
   );

   // 4 ns period
   always #2 clk = ~clk;

   function automatic logic [`DC_ADR_W-1:0] mem_word(input logic [`DC_ADR_W-1:0] adr);
      return adr ^ MEM_KEY;
   endfunction

   // Lane mask built from the byte select
   function automatic logic [`DC_ADR_W-1:0] byte_merge(input logic [`DC_ADR_W-1:0] old_w,
                                                        input logic [`DC_ADR_W-1:0] new_w,
                                                        input logic [3:0] bsel);
      logic [`DC_ADR_W-1:0] mask;
      mask = {{8{bsel[3]}}, {8{bsel[2]}}, {8{bsel[1]}}, {8{bsel[0]}}};
      return (new_w & mask) | (old_w & ~mask);
   endfunction

   task automatic add_vec(input string name, input op_t op, input logic [`DC_ADR_W-1:0] adr,
                          input logic [`DC_ADR_W-1:0] dat, input logic [3:0] bsel,
                          input logic [`DC_ADR_W-1:0] exp_dat, input logic chk_dat,
                          input logic exp_refill);
      vec_name[n_vec]       = name;
      vec[n_vec].op         = op;
      vec[n_vec].adr        = adr;
      vec[n_vec].dat        = dat;
      vec[n_vec].bsel       = bsel;
      vec[n_vec].exp_dat    = exp_dat;
      vec[n_vec].chk_dat    = chk_dat;
      vec[n_vec].exp_refill = exp_refill;
      n_vec++;
   endtask

   // Blocks A, B, C share set 3, LRU traced by hand
   task automatic build_table();
      logic [`DC_ADR_W-1:0] merged;
      merged = byte_merge(mem_word(32'h1038), 32'hdead_beef, 4'b0101);
      add_vec("rd_miss_a_w1", OP_RD, 32'h1034, '0, 4'h0, mem_word(32'h1034), 1'b1, 1'b1);
      add_vec("rd_hit_a_w3", OP_RD, 32'h103c, '0, 4'h0, mem_word(32'h103c), 1'b1, 1'b0);
      add_vec("wr_hit_a_w2", OP_WR, 32'h1038, 32'hdead_beef, 4'b0101, '0, 1'b0, 1'b0);
      add_vec("rd_merged_a_w2", OP_RD, 32'h1038, '0, 4'h0, merged, 1'b1, 1'b0);
      add_vec("wr_miss_set4", OP_WR, 32'h5040, 32'h1234_5678, 4'hf, '0, 1'b0, 1'b0);
      add_vec("rd_after_wr_miss", OP_RD, 32'h5040, '0, 4'h0, mem_word(32'h5040), 1'b1, 1'b1);
      add_vec("rd_miss_b", OP_RD, 32'h2030, '0, 4'h0, mem_word(32'h2030), 1'b1, 1'b1);
      add_vec("rd_hit_a_w0", OP_RD, 32'h1030, '0, 4'h0, mem_word(32'h1030), 1'b1, 1'b0);
      // C takes the way of B
      add_vec("rd_miss_c", OP_RD, 32'h3030, '0, 4'h0, mem_word(32'h3030), 1'b1, 1'b1);
      add_vec("rd_a_kept", OP_RD, 32'h1038, '0, 4'h0, merged, 1'b1, 1'b0);
      add_vec("rd_b_evicted", OP_RD, 32'h2034, '0, 4'h0, mem_word(32'h2034), 1'b1, 1'b1);
      add_vec("spr_inv_set3", OP_SPR, 32'h0030, '0, 4'h0, '0, 1'b0, 1'b0);
      add_vec("rd_a_after_inv", OP_RD, 32'h1030, '0, 4'h0, mem_word(32'h1030), 1'b1, 1'b1);
      add_vec("rd_b_after_inv", OP_RD, 32'h2030, '0, 4'h0, mem_word(32'h2030), 1'b1, 1'b1);
      // no write back, so the merged bytes are gone
      add_vec("rd_a_unmerged", OP_RD, 32'h1038, '0, 4'h0, mem_word(32'h1038), 1'b1, 1'b0);
   endtask

   // Drive one row, hold it until acknowledged
   task automatic run_vec(input int i);
      u_checker.begin_test(vec_name[i], vec[i].op == OP_SPR, vec[i].exp_dat,
                           vec[i].chk_dat, vec[i].exp_refill);
      if (vec[i].op == OP_SPR) begin
         spr_stb  = 1'b1;
         spr_we   = 1'b1;
         spr_addr = `DC_SPR_DCBIR;
         spr_dat  = vec[i].adr;
      end else begin
         cpu_req.adr   = vec[i].adr;
         cpu_req.dat   = vec[i].dat;
         cpu_req.we    = (vec[i].op == OP_WR);
         cpu_req.bsel  = vec[i].bsel;
         cpu_req_valid = 1'b1;
      end
      @(negedge clk);
      while (!(cpu_ack || spr_ack)) begin
         @(negedge clk);
      end
      // Ack cycle ends at the next rising edge
      @(posedge clk);
      #1;
      cpu_req_valid = 1'b0;
      spr_stb       = 1'b0;
      spr_we        = 1'b0;
   endtask

   // Wrapping beats from the missed word, random pauses of up to 3 cycles
   task automatic serve_refill(input logic [`DC_ADR_W-1:0] miss_adr);
      logic [1:0] word;
      int         gap;
      for (int k = 0; k < 4; k++) begin
         gap = $random(seed) & 3;
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
         word            = miss_adr[3:2] + 2'(k);
         refill_beat.adr = {miss_adr[`DC_ADR_W-1:4], word, 2'b00};
         refill_beat.dat = mem_word(refill_beat.adr);
         refill_we       = 1'b1;
         @(posedge clk);
         #1;
         refill_we = 1'b0;
      end
   endtask

   // Memory side, looks at the request level just after each edge
   always begin
      @(posedge clk);
      #1;
      if (refill_req) begin
         serve_refill(cpu_req.adr);
      end
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, a test never finished", cycle_cnt);
      $display("TB FAILED");
      $finish;
   end

   initial begin
      clk           = 1'b0;
      rst           = 1'b1;
      cpu_req_valid = 1'b0;
      cpu_req       = '0;
      refill_we     = 1'b0;
      refill_beat   = '0;
      spr_stb       = 1'b0;
      spr_we        = 1'b0;
      spr_addr      = '0;
      spr_dat       = '0;
      seed          = 32'hf9f84d8a;
      n_vec         = 0;
      build_table();
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;
      // Tag sweep clears one set per cycle
      repeat (16) @(posedge clk);
      #1;
      for (int i = 0; i < n_vec; i++) begin
         run_vec(i);
      end
      u_checker.report_counts(fails);
      if (fails == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== tb/dcache_checker.sv ====
// Result checker for the data cache testbench, compares acks, read data and refill requests
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_checker (
   input  logic                  clk,
   input  logic                  cpu_ack_i,
   input  logic [`DC_ADR_W-1:0]  cpu_dat_i,
   input  logic                  refill_req_i,
   input  logic                  spr_ack_i
);

   // Expectations of the test in flight
   string                 cur_name;
   logic                  cur_spr;
   logic [`DC_ADR_W-1:0]  cur_exp;
   logic                  cur_chk;
   logic                  cur_refill;
   logic                  active;
   logic                  saw_refill;
   int                    run_cnt;
   int                    pass_cnt;
   int                    fail_cnt;

   initial begin
      active   = 1'b0;
      run_cnt  = 0;
      pass_cnt = 0;
      fail_cnt = 0;
   end

   // Called by the stimulus side before it drives a request
   task automatic begin_test(input string name, input logic is_spr,
                             input logic [`DC_ADR_W-1:0] exp_dat, input logic chk_dat,
                             input logic exp_refill);
      cur_name   = name;
      cur_spr    = is_spr;
      cur_exp    = exp_dat;
      cur_chk    = chk_dat;
      cur_refill = exp_refill;
      saw_refill = 1'b0;
      active     = 1'b1;
   endtask

   // One line per finished test, first problem found wins
   task automatic finish_test();
      active = 1'b0;
      run_cnt++;
      if ((cur_spr && !spr_ack_i) || (!cur_spr && !cpu_ack_i)) begin
         fail_cnt++;
         $display("Test %s was acknowledged on the wrong bus", cur_name);
      end else if (saw_refill != cur_refill) begin
         fail_cnt++;
         $display("Fail %s: refill request expected %0b actual %0b",
                  cur_name, cur_refill, saw_refill);
      end else if (cur_chk && (cpu_dat_i !== cur_exp)) begin
         fail_cnt++;
         $display("Fail %s: read data expected %08h actual %08h",
                  cur_name, cur_exp, cpu_dat_i);
      end else begin
         pass_cnt++;
         $display("Pass %s", cur_name);
      end
   endtask

   // Closing count line, failures handed back to the top
   task automatic report_counts(output int fails);
      $display("Tests run %0d, passed %0d, failed %0d", run_cnt, pass_cnt, fail_cnt);
      fails = fail_cnt;
   endtask

   // Sample mid-cycle, DUT outputs are settled at the falling edge
   always @(negedge clk) begin
      if (active) begin
         // A refill anywhere in the test counts
         if (refill_req_i) begin
            saw_refill = 1'b1;
         end
         if (cpu_ack_i || spr_ack_i) begin
            finish_test();
         end
      end
   end

endmodule

// ==== src/dcache_top.sv ====
// Two-way data cache top, controller with tag RAM, two way RAMs and LRU
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_top (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      cpu_req_valid_i,
   input  dcache_pkg::cpu_req_t      cpu_req_i,
   input  logic                      refill_we_i,
   input  dcache_pkg::refill_beat_t  refill_beat_i,
   input  logic                      spr_stb_i,
   input  logic                      spr_we_i,
   input  logic [15:0]               spr_addr_i,
   input  logic [`DC_ADR_W-1:0]      spr_dat_i,
   output logic                      cpu_ack_o,
   output logic [`DC_ADR_W-1:0]      cpu_dat_o,
   output logic                      refill_req_o,
   output logic                      spr_ack_o
);
   import dcache_pkg::*;

   localparam int WADDR_W = `DC_SET_W + `DC_WORD_IDX_W;
   localparam int BYTE_W  = `DC_BLOCK_W - `DC_WORD_IDX_W;
   localparam int IDX_HI  = `DC_SET_W + `DC_BLOCK_W - 1;

   tag_line_t               tag_line;
   tag_line_t               tag_din;
   logic                    tag_we;
   logic [`DC_SET_W-1:0]    tag_windex;
   logic [1:0]              way_hit;
   logic [1:0]              way_we;
   logic [1:0]              access;
   logic [1:0]              victim;
   logic                    lru_next;
   logic                    capture;
   logic                    way_sel_refill;
   logic [WADDR_W-1:0]      way_waddr;
   logic [`DC_ADR_W-1:0]    way_dat [2];
   logic [`DC_ADR_W-1:0]    wr_dat;
   logic [`DC_ADR_W-1:0]    way_din;

   // Refill beats and merged CPU writes share the way write port
   assign way_din = way_sel_refill ? refill_beat_i.dat : wr_dat;

   dcache_ctrl u_ctrl (
      .clk              (clk),
      .rst              (rst),
      .req_valid_i      (cpu_req_valid_i),
      .req_i            (cpu_req_i),
      .way_hit_i        (way_hit),
      .tag_line_i       (tag_line),
      .lru_next_i       (lru_next),
      .victim_i         (victim),
      .refill_we_i      (refill_we_i),
      .refill_beat_i    (refill_beat_i),
      .spr_stb_i        (spr_stb_i),
      .spr_we_i         (spr_we_i),
      .spr_addr_i       (spr_addr_i),
      .spr_dat_i        (spr_dat_i),
      .cpu_ack_o        (cpu_ack_o),
      .refill_req_o     (refill_req_o),
      .spr_ack_o        (spr_ack_o),
      .tag_we_o         (tag_we),
      .tag_windex_o     (tag_windex),
      .tag_din_o        (tag_din),
      .way_we_o         (way_we),
      .way_waddr_o      (way_waddr),
      .way_sel_refill_o (way_sel_refill),
      .access_o         (access),
      .capture_o        (capture)
   );

   dcache_lookup u_lookup (
      .tag_line_i (tag_line),
      .req_i      (cpu_req_i),
      .way_dat0_i (way_dat[0]),
      .way_dat1_i (way_dat[1]),
      .way_hit_o  (way_hit),
      .rd_dat_o   (cpu_dat_o),
      .wr_dat_o   (wr_dat)
   );

   dcache_lru u_lru (
      .clk       (clk),
      .rst       (rst),
      .lru_i     (tag_line.lru),
      .access_i  (access),
      .capture_i (capture),
      .lru_o     (lru_next),
      .victim_o  (victim)
   );

   // Tag RAM, one line per set, read at the request index
   dcache_ram #(
      .payload_t (tag_line_t),
      .ADDR_W    (`DC_SET_W)
   ) u_tag_ram (
      .clk     (clk),
      .raddr_i (cpu_req_i.adr[IDX_HI:`DC_BLOCK_W]),
      .waddr_i (tag_windex),
      .we_i    (tag_we),
      .din_i   (tag_din),
      .dout_o  (tag_line)
   );

   // One word RAM per way, addressed by set and word
   for (genvar w = 0; w < 2; w++) begin : g_way
      dcache_ram #(
         .payload_t (logic [`DC_ADR_W-1:0]),
         .ADDR_W    (WADDR_W)
      ) u_way_ram (
         .clk     (clk),
         .raddr_i (cpu_req_i.adr[IDX_HI:BYTE_W]),
         .waddr_i (way_waddr),
         .we_i    (way_we[w]),
         .din_i   (way_din),
         .dout_o  (way_dat[w])
      );
   end

endmodule

// ==== src/dcache_ctrl.sv ====
// Data cache FSM for lookups, refill, SPR invalidate and the reset sweep
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_ctrl (
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   req_valid_i,
   input  dcache_pkg::cpu_req_t                   req_i,
   input  logic [1:0]                             way_hit_i,
   input  dcache_pkg::tag_line_t                  tag_line_i,
   input  logic                                   lru_next_i,
   input  logic [1:0]                             victim_i,
   input  logic                                   refill_we_i,
   input  dcache_pkg::refill_beat_t               refill_beat_i,
   input  logic                                   spr_stb_i,
   input  logic                                   spr_we_i,
   input  logic [15:0]                            spr_addr_i,
   input  logic [`DC_ADR_W-1:0]                   spr_dat_i,
   output logic                                   cpu_ack_o,
   output logic                                   refill_req_o,
   output logic                                   spr_ack_o,
   output logic                                   tag_we_o,
   output logic [`DC_SET_W-1:0]                   tag_windex_o,
   output dcache_pkg::tag_line_t                  tag_din_o,
   output logic [1:0]                             way_we_o,
   output logic [`DC_SET_W+`DC_WORD_IDX_W-1:0]    way_waddr_o,
   output logic                                   way_sel_refill_o,
   output logic [1:0]                             access_o,
   output logic                                   capture_o
);
   import dcache_pkg::*;

   localparam int WORDS  = 1 << `DC_WORD_IDX_W;
   localparam int BYTE_W = `DC_BLOCK_W - `DC_WORD_IDX_W;
   localparam int IDX_HI = `DC_SET_W + `DC_BLOCK_W - 1;

   dc_state_t                 state;
   logic                      sweep_busy;
   logic [`DC_SET_W-1:0]      sweep_idx;
   logic [`DC_SET_W-1:0]      inv_idx;
   logic [WORDS-1:0]          refill_valid;
   logic [WORDS-1:0]          beat_mask;
   logic                      refill_first;
   logic                      refill_done;
   logic                      inv_req;
   logic                      hit;
   logic [`DC_SET_W-1:0]      req_idx;
   logic [`DC_TAG_W-1:0]      beat_tag;

   assign hit     = |way_hit_i;
   assign req_idx = req_i.adr[IDX_HI:`DC_BLOCK_W];

   // Beat decode, word slot and new tag
   assign beat_tag = refill_beat_i.adr[`DC_ADR_W-1 -: `DC_TAG_W];
   always_comb begin
      beat_mask = '0;
      beat_mask[refill_beat_i.adr[`DC_BLOCK_W-1:BYTE_W]] = 1'b1;
   end

   // No word in yet, or this beat fills the last hole
   assign refill_first = (refill_valid == '0);
   assign refill_done  = &(refill_valid | beat_mask);

   // Block invalidate write on the SPR bus
   assign inv_req   = spr_stb_i && spr_we_i && (spr_addr_i == `DC_SPR_DCBIR);
   assign spr_ack_o = inv_req && !sweep_busy &&
                      ((state == IDLE) || (state == INVALIDATE));

   assign refill_req_o     = (state == REFILL);
   assign way_sel_refill_o = (state == REFILL);

   // State register, reset sweep counter and refill word tracking
   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= IDLE;
         sweep_busy   <= 1'b1;
         sweep_idx    <= '0;
         refill_valid <= '0;
      end else begin
         // Sweep walks all sets once
         if (sweep_busy) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) begin
               sweep_busy <= 1'b0;
            end
         end
         case (state)
            IDLE: begin
               // SPR invalidate wins over a CPU request
               if (spr_ack_o) begin
                  state <= INVALIDATE;
               end else if (req_valid_i && !sweep_busy) begin
                  state <= req_i.we ? WRITE : READ;
               end
            end
            READ: begin
               if (hit) begin
                  state <= IDLE;
               end else begin
                  refill_valid <= '0;
                  state        <= REFILL;
               end
            end
            WRITE: begin
               state <= IDLE;
            end
            REFILL: begin
               if (refill_we_i) begin
                  refill_valid <= refill_valid | beat_mask;
                  // Back to IDLE for a re-read that then hits
                  if (refill_done) begin
                     refill_valid <= '0;
                     state        <= IDLE;
                  end
               end
            end
            INVALIDATE: begin
               if (!inv_req) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Set to invalidate, taken with each acknowledged strobe
   always_ff @(posedge clk) begin
      if (spr_ack_o) begin
         inv_idx <= spr_dat_i[IDX_HI:`DC_BLOCK_W];
      end
   end

   // RAM write strobes, tag update and acknowledgements
   always_comb begin
      cpu_ack_o     = 1'b0;
      tag_we_o      = 1'b0;
      tag_windex_o  = req_idx;
      // Default keeps the line, LRU follows the accessed way
      tag_din_o     = tag_line_i;
      tag_din_o.lru = lru_next_i;
      way_we_o      = '0;
      way_waddr_o   = req_i.adr[IDX_HI:BYTE_W];
      access_o      = '0;
      capture_o     = 1'b0;
      case (state)
         READ: begin
            if (hit) begin
               cpu_ack_o = 1'b1;
               access_o  = way_hit_i;
               tag_we_o  = 1'b1;
            end else begin
               capture_o = 1'b1;
            end
         end
         WRITE: begin
            // Miss is acked and leaves the cache untouched
            cpu_ack_o = 1'b1;
            if (hit) begin
               way_we_o = way_hit_i;
               access_o = way_hit_i;
               tag_we_o = 1'b1;
            end
         end
         REFILL: begin
            tag_windex_o = refill_beat_i.adr[IDX_HI:`DC_BLOCK_W];
            way_waddr_o  = refill_beat_i.adr[IDX_HI:BYTE_W];
            if (refill_we_i) begin
               way_we_o = victim_i;
               tag_we_o = refill_first || refill_done;
               for (int w = 0; w < 2; w++) begin
                  if (victim_i[w] && refill_done) begin
                     tag_din_o.way[w].valid = 1'b1;
                     tag_din_o.way[w].tag   = beat_tag;
                  end else if (victim_i[w]) begin
                     // Old block gone from the first beat on
                     tag_din_o.way[w].valid = 1'b0;
                  end
               end
               if (refill_done) begin
                  access_o = victim_i;
               end
            end
         end
         INVALIDATE: begin
            // Both ways and the history cleared
            tag_we_o     = 1'b1;
            tag_windex_o = inv_idx;
            tag_din_o    = '0;
         end
         default: begin
         end
      endcase
      // Reset sweep owns the tag write port
      if (sweep_busy) begin
         tag_we_o     = 1'b1;
         tag_windex_o = sweep_idx;
         tag_din_o    = '0;
      end
   end

endmodule

// ==== src/dcache_lru.sv ====
// Two-way LRU history update and refill victim register
`timescale 1ns/10ps

module dcache_lru (
   input  logic       clk,
   input  logic       rst,
   input  logic       lru_i,
   input  logic [1:0] access_i,
   input  logic       capture_i,
   output logic       lru_o,
   output logic [1:0] victim_o
);

   // History bit names the way not used most recently
   // no access leaves it as read
   always_comb begin
      lru_o = lru_i;
      if (access_i[0]) begin
         lru_o = 1'b1;
      end else if (access_i[1]) begin
         lru_o = 1'b0;
      end
   end

   // Victim frozen at the miss, held for the whole refill
   always_ff @(posedge clk) begin
      if (rst) begin
         victim_o <= 2'b01;
      end else if (capture_i) begin
         victim_o <= lru_i ? 2'b10 : 2'b01;
      end
   end

endmodule

// ==== src/dcache_lookup.sv ====
// Tag compare, hit way data select and byte-select write merge
`timescale 1ns/10ps
`include "dcache_settings.svh"

module dcache_lookup (
   input  dcache_pkg::tag_line_t  tag_line_i,
   input  dcache_pkg::cpu_req_t   req_i,
   input  logic [`DC_ADR_W-1:0]   way_dat0_i,
   input  logic [`DC_ADR_W-1:0]   way_dat1_i,
   output logic [1:0]             way_hit_o,
   output logic [`DC_ADR_W-1:0]   rd_dat_o,
   output logic [`DC_ADR_W-1:0]   wr_dat_o
);

   // Number of byte lanes in a word
   localparam int LANES = `DC_ADR_W / 8;

   logic [`DC_TAG_W-1:0] req_tag;

   // Tag field sits at the top of the address
   assign req_tag = req_i.adr[`DC_ADR_W-1 -: `DC_TAG_W];

   // Per-way match, only valid entries count
   always_comb begin
      for (int w = 0; w < 2; w++) begin
         way_hit_o[w] = tag_line_i.way[w].valid &&
                        (tag_line_i.way[w].tag == req_tag);
      end
   end

   // At most one way hits
   // way 0 is the fallback when none does
   assign rd_dat_o = way_hit_o[1] ? way_dat1_i : way_dat0_i;

   // Selected bytes from the CPU, the rest kept from the stored word
   always_comb begin
      for (int b = 0; b < LANES; b++) begin
         if (req_i.bsel[b]) begin
            wr_dat_o[b*8 +: 8] = req_i.dat[b*8 +: 8];
         end else begin
            wr_dat_o[b*8 +: 8] = rd_dat_o[b*8 +: 8];
         end
      end
   end

endmodule

// ==== src/dcache_ram.sv ====
// Single-clock dual-port RAM with registered read and write-first bypass
`timescale 1ns/10ps

module dcache_ram #(
   parameter type payload_t = logic [31:0],
   parameter int  ADDR_W    = 4
) (
   input  logic              clk,
   input  logic [ADDR_W-1:0] raddr_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic              we_i,
   input  payload_t          din_i,
   output payload_t          dout_o
);

   // Storage array, contents undefined until written
   payload_t mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      // Same-cycle collision returns the new value
      if (we_i && (raddr_i == waddr_i)) begin
         dout_o <= din_i;
      end else begin
         dout_o <= mem[raddr_i];
      end
   end

endmodule

// ==== src/dcache_pkg.sv ====
// Shared types for the data cache, FSM states and packed bus records
`include "dcache_settings.svh"

package dcache_pkg;

   // Controller states
   typedef enum logic [2:0] {
      IDLE,
      READ,
      WRITE,
      REFILL,
      INVALIDATE
   } dc_state_t;

   // One way in the tag RAM
   typedef struct packed {
      logic                 valid;
      logic [`DC_TAG_W-1:0] tag;
   } tag_entry_t;

   // Whole set, LRU bit on top, way 1 above way 0
   typedef struct packed {
      logic              lru;
      tag_entry_t [1:0]  way;
   } tag_line_t;

   // CPU request, held stable until ack
   typedef struct packed {
      logic [`DC_ADR_W-1:0] adr;
      logic [`DC_ADR_W-1:0] dat;
      logic                 we;
      logic [3:0]           bsel;
   } cpu_req_t;

   // Refill beat from the memory side
   typedef struct packed {
      logic [`DC_ADR_W-1:0] adr;
      logic [`DC_ADR_W-1:0] dat;
   } refill_beat_t;

endpackage

// ==== src/dcache_settings.svh ====
// Global sizing constants for the two-way set-associative data cache
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// Address and data word width
`define DC_ADR_W 32

// Byte offset inside a block, 16-byte blocks
`define DC_BLOCK_W 4

// Set index width, 16 sets
`define DC_SET_W 4

// Tag is whatever sits above index and offset
`define DC_TAG_W (`DC_ADR_W - `DC_BLOCK_W - `DC_SET_W)

// Word within a block, four words per block
`define DC_WORD_IDX_W 2

// SPR address of the block invalidate register
`define DC_SPR_DCBIR 16'h3003

`endif
